// ==== src/csr_op_pkg.sv ====
// Access protocol types and widths; data is fixed at one 32-bit word, hart field sized for up to 8 harts
package csr_op_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int CSR_DATA_W = 32;  // One word, not a parameter
  localparam int CSR_ADDR_W = 12;  // Standard CSR address space
  localparam int HART_ID_W  = 3;   // Low clog2(NUM_HARTS) bits in use

  //////////////////////////////
  // Access opcodes
  //////////////////////////////

  // Encoded like funct3[1:0] of the Zicsr instructions
  // 2'b00 is not a legal access
  typedef enum logic [1:0] {
    CSR_OP_RW = 2'b01,  // Swap
    CSR_OP_RS = 2'b10,  // Read and set bits
    CSR_OP_RC = 2'b11   // Read and clear bits
  } csr_op_e;

endpackage : csr_op_pkg

// ==== src/csr_defs_pkg.sv ====
// Machine-mode register map only; RV32I misa, no counters, no trap or interrupt CSRs
package csr_defs_pkg;

  //////////////////////////////
  // Addresses
  //////////////////////////////

  // Machine information, read-only block (bits 11:10 set)
  localparam logic [11:0] CSR_ADDR_MVENDORID = 12'hF11;
  localparam logic [11:0] CSR_ADDR_MARCHID   = 12'hF12;
  localparam logic [11:0] CSR_ADDR_MIMPID    = 12'hF13;
  localparam logic [11:0] CSR_ADDR_MHARTID   = 12'hF14;

  // Machine trap setup and handling
  localparam logic [11:0] CSR_ADDR_MSTATUS   = 12'h300;
  localparam logic [11:0] CSR_ADDR_MISA      = 12'h301;
  localparam logic [11:0] CSR_ADDR_MTVEC     = 12'h305;
  localparam logic [11:0] CSR_ADDR_MSCRATCH  = 12'h340;
  localparam logic [11:0] CSR_ADDR_MEPC      = 12'h341;

  //////////////////////////////
  // Fixed values
  //////////////////////////////

  localparam logic [31:0] CSR_VAL_MVENDORID = 32'h0000_0000;  // Non-commercial
  localparam logic [31:0] CSR_VAL_MARCHID   = 32'h0000_0000;  // Not allocated
  localparam logic [31:0] CSR_VAL_MIMPID    = 32'h0000_0001;  // First implementation
  localparam logic [31:0] CSR_VAL_MISA      = 32'h4000_0100;  // MXL=1, I extension

  //////////////////////////////
  // Writable fields
  //////////////////////////////

  localparam int CSR_MSTATUS_BIT_MIE  = 3;
  localparam int CSR_MSTATUS_BIT_MPIE = 7;

  localparam logic [31:0] CSR_MSTATUS_WMASK = (32'h1 << CSR_MSTATUS_BIT_MIE)
                                            | (32'h1 << CSR_MSTATUS_BIT_MPIE);
  localparam logic [31:0] CSR_MTVEC_WMASK   = 32'hFFFF_FFFC;  // Base only
  localparam logic [31:0] CSR_MEPC_WMASK    = 32'hFFFF_FFFC;  // No compressed ISA

  localparam logic [1:0]  CSR_MTVEC_MODE_DIRECT = 2'b00;

endpackage : csr_defs_pkg

// ==== src/csr_req_if.sv ====
// Internal valid/ready links between dispatcher, per-hart files and collector; payload stable while valid
`timescale 1ns/1ns

//////////////////////////////
// Request link
//////////////////////////////

interface csr_req_if import csr_op_pkg::*; ();

  logic                  valid;
  logic                  ready;  // May follow valid in the same cycle
  csr_op_e               op;
  logic [CSR_ADDR_W-1:0] addr;
  logic [CSR_DATA_W-1:0] wdata;

  // Dispatcher side
  modport src (output valid, output op, output addr, output wdata, input ready);

  // Register file side
  modport dst (input valid, input op, input addr, input wdata, output ready);

endinterface : csr_req_if

//////////////////////////////
// Response link
//////////////////////////////

interface csr_rsp_if import csr_op_pkg::*; ();

  logic                  valid;
  logic                  ready;
  logic [CSR_DATA_W-1:0] rdata;  // Old register value, zero on error
  logic                  err;

  // Register file side
  modport src (output valid, output rdata, output err, input ready);

  // Collector side
  modport dst (input valid, input rdata, input err, output ready);

endinterface : csr_rsp_if

// ==== src/csr_dispatch.sv ====
// Purely combinational; NUM_HARTS a power of two so every hart number decodes, upper hart bits ignored
`timescale 1ns/1ns

module csr_dispatch import csr_op_pkg::*; #(
  parameter int NUM_HARTS = 4
) (
  input  logic                  clk_i,   // Assertion only
  input  logic                  rstn_i,  // Assertion only

  // Shared request port
  input  logic                  req_valid_i,
  input  logic [HART_ID_W-1:0]  req_hart_i,
  input  csr_op_e               req_op_i,
  input  logic [CSR_ADDR_W-1:0] req_addr_i,
  input  logic [CSR_DATA_W-1:0] req_wdata_i,
  output logic                  req_ready_o,

  // One link per hart
  csr_req_if.src                hart_req [NUM_HARTS]
);

  localparam int SEL_W = $clog2(NUM_HARTS);

  logic [SEL_W-1:0]     hart_sel;
  logic [NUM_HARTS-1:0] hart_ready;  // Gathered per-hart ready

  assign hart_sel = req_hart_i[SEL_W-1:0];  // Only the decoded bits

  //////////////////////////////
  // Fan-out
  //////////////////////////////

  for (genvar g = 0; g < NUM_HARTS; g++) begin : g_fan
    // Valid only toward the addressed hart
    assign hart_req[g].valid = req_valid_i && (hart_sel == SEL_W'(g));
    // Payload broadcast, harmless to the others
    assign hart_req[g].op    = req_op_i;
    assign hart_req[g].addr  = req_addr_i;
    assign hart_req[g].wdata = req_wdata_i;
    assign hart_ready[g]     = hart_req[g].ready;
  end

  // Back-pressure comes from the selected hart only
  assign req_ready_o = hart_ready[hart_sel];

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Upstream must hold a stalled request, else the routing below would change mid-transfer
  property p_req_hold;
    @(posedge clk_i) disable iff (!rstn_i)
      req_valid_i && !req_ready_o
      |=> req_valid_i && $stable({req_hart_i, req_op_i, req_addr_i, req_wdata_i});
  endproperty

  a_req_hold : assert property (p_req_hold)
    else $error("request dropped or changed while stalled");

endmodule : csr_dispatch

// ==== src/csr_file.sv ====
// One hart, machine mode only; no trap entry, MRET or interrupts; MTVEC_RESET low two bits must be zero
`timescale 1ns/1ns

module csr_file import csr_op_pkg::*, csr_defs_pkg::*; #(
  parameter int unsigned           HART_ID     = 0,
  parameter logic [CSR_DATA_W-1:0] MTVEC_RESET = 32'h0000_0100
) (
  input  logic   clk_i,
  input  logic   rstn_i,
  csr_req_if.dst req,  // From dispatcher
  csr_rsp_if.src rsp   // To collector
);

  // Architectural state
  logic [CSR_DATA_W-1:0] mstatus_q;   // MIE and MPIE only
  logic [CSR_DATA_W-1:0] mtvec_q;     // Mode bits stay direct
  logic [CSR_DATA_W-1:0] mscratch_q;
  logic [CSR_DATA_W-1:0] mepc_q;      // Bits 1:0 stay zero

  // Access path
  logic [CSR_DATA_W-1:0] rd_val;      // Current value of addressed CSR
  logic [CSR_DATA_W-1:0] new_val;     // Value after the op, before masking
  logic                  addr_hit;
  logic                  wants_write;
  logic                  read_only;
  logic                  acc_err;
  logic                  acc;         // Request accepted this cycle
  logic                  wr_fire;

  // Response register
  logic                  rsp_valid_q;
  logic [CSR_DATA_W-1:0] rsp_rdata_q;
  logic                  rsp_err_q;

  //////////////////////////////
  // Read and decode
  //////////////////////////////

  always_comb begin
    rd_val   = '0;
    addr_hit = 1'b1;
    case (req.addr)
      CSR_ADDR_MVENDORID: rd_val = CSR_VAL_MVENDORID;
      CSR_ADDR_MARCHID:   rd_val = CSR_VAL_MARCHID;
      CSR_ADDR_MIMPID:    rd_val = CSR_VAL_MIMPID;
      CSR_ADDR_MHARTID:   rd_val = CSR_DATA_W'(HART_ID);
      CSR_ADDR_MSTATUS:   rd_val = mstatus_q;
      CSR_ADDR_MISA:      rd_val = CSR_VAL_MISA;  // WARL, writes ignored
      CSR_ADDR_MTVEC:     rd_val = mtvec_q;
      CSR_ADDR_MSCRATCH:  rd_val = mscratch_q;
      CSR_ADDR_MEPC:      rd_val = mepc_q;
      default:            addr_hit = 1'b0;  // Unknown address
    endcase
  end

  // Read-modify-write
  always_comb begin
    case (req.op)
      CSR_OP_RW: new_val = req.wdata;
      CSR_OP_RS: new_val = rd_val | req.wdata;
      CSR_OP_RC: new_val = rd_val & ~req.wdata;
      default:   new_val = rd_val;  // Illegal op, value unchanged
    endcase
  end

  // Set/clear with zero mask is a pure read
  assign wants_write = (req.op == CSR_OP_RW) || (req.wdata != '0);
  assign read_only   = &req.addr[11:10];
  assign acc_err     = !addr_hit || (read_only && wants_write);

  // Handshake, one-deep response buffer
  assign req.ready = !rsp_valid_q || rsp.ready;
  assign acc       = req.valid && req.ready;
  assign wr_fire   = acc && !acc_err && wants_write;

  //////////////////////////////
  // State update
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      mstatus_q  <= '0;
      mtvec_q    <= (MTVEC_RESET & CSR_MTVEC_WMASK) | {30'b0, CSR_MTVEC_MODE_DIRECT};
      mscratch_q <= '0;
      mepc_q     <= '0;
    end else if (wr_fire) begin
      case (req.addr)
        CSR_ADDR_MSTATUS:  mstatus_q  <= new_val & CSR_MSTATUS_WMASK;
        CSR_ADDR_MTVEC:    mtvec_q    <= (new_val & CSR_MTVEC_WMASK)
                                       | {30'b0, CSR_MTVEC_MODE_DIRECT};
        CSR_ADDR_MSCRATCH: mscratch_q <= new_val;
        CSR_ADDR_MEPC:     mepc_q     <= new_val & CSR_MEPC_WMASK;
        default: ;  // misa and the read-only block hold
      endcase
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      rsp_valid_q <= 1'b0;
    end else if (acc) begin
      rsp_valid_q <= 1'b1;  // Refill wins over drain
    end else if (rsp.ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc) begin
      rsp_rdata_q <= acc_err ? '0 : rd_val;  // Old value
      rsp_err_q   <= acc_err;
    end
  end

  assign rsp.valid = rsp_valid_q;
  assign rsp.rdata = rsp_rdata_q;
  assign rsp.err   = rsp_err_q;

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Rejected access leaves every writable register as it was
  a_err_no_write : assert property (
    @(posedge clk_i) disable iff (!rstn_i)
      acc && acc_err |=> $stable({mstatus_q, mtvec_q, mscratch_q, mepc_q}))
    else $error("rejected access modified state");

  // Response held until the collector takes it
  a_rsp_hold : assert property (
    @(posedge clk_i) disable iff (!rstn_i)
      rsp.valid && !rsp.ready |=> rsp.valid && $stable({rsp.rdata, rsp.err}))
    else $error("response dropped or changed while stalled");

endmodule : csr_file

// ==== src/csr_resp_arb.sv ====
// Round-robin over NUM_HARTS (power of two) response links into one registered output, one grant per cycle
`timescale 1ns/1ns

module csr_resp_arb import csr_op_pkg::*; #(
  parameter int NUM_HARTS = 4
) (
  input  logic                  clk_i,
  input  logic                  rstn_i,

  csr_rsp_if.dst                hart_rsp [NUM_HARTS],  // From per-hart files

  // Shared response port
  output logic                  resp_valid_o,
  output logic [HART_ID_W-1:0]  resp_hart_o,
  output logic [CSR_DATA_W-1:0] resp_rdata_o,
  output logic                  resp_err_o,
  input  logic                  resp_ready_i
);

  localparam int SEL_W = $clog2(NUM_HARTS);

  logic [NUM_HARTS-1:0]  hart_valid;
  logic [CSR_DATA_W-1:0] hart_rdata [NUM_HARTS];
  logic [NUM_HARTS-1:0]  hart_err;
  logic [NUM_HARTS-1:0]  gnt_vec;      // One-hot ready back to harts

  logic [SEL_W-1:0]      last_q;       // Last hart granted
  logic [SEL_W-1:0]      gnt_idx;
  logic                  gnt_found;
  logic                  out_free;     // Output register empty or draining
  logic                  load;

  logic                  out_valid_q;
  logic [SEL_W-1:0]      out_hart_q;
  logic [CSR_DATA_W-1:0] out_rdata_q;
  logic                  out_err_q;

  // Flatten the interface array
  for (genvar g = 0; g < NUM_HARTS; g++) begin : g_gather
    assign hart_valid[g]   = hart_rsp[g].valid;
    assign hart_rdata[g]   = hart_rsp[g].rdata;
    assign hart_err[g]     = hart_rsp[g].err;
    assign hart_rsp[g].ready = gnt_vec[g];
  end

  //////////////////////////////
  // Round-robin pick
  //////////////////////////////

  // Search starts one past the last grant, wraps by width
  always_comb begin
    logic [SEL_W-1:0] cand;
    cand      = '0;
    gnt_found = 1'b0;
    gnt_idx   = last_q;
    for (int i = 1; i <= NUM_HARTS; i++) begin
      cand = last_q + SEL_W'(i);
      if (!gnt_found && hart_valid[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand;
      end
    end
  end

  assign out_free = !out_valid_q || resp_ready_i;
  assign load     = out_free && gnt_found;

  for (genvar g = 0; g < NUM_HARTS; g++) begin : g_gnt
    assign gnt_vec[g] = load && (gnt_idx == SEL_W'(g));
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      out_valid_q <= 1'b0;
      last_q      <= SEL_W'(NUM_HARTS - 1);  // Hart 0 first after reset
    end else begin
      if (load) begin
        out_valid_q <= 1'b1;
        last_q      <= gnt_idx;
      end else if (resp_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      out_hart_q  <= gnt_idx;
      out_rdata_q <= hart_rdata[gnt_idx];
      out_err_q   <= hart_err[gnt_idx];
    end
  end

  assign resp_valid_o = out_valid_q;
  assign resp_hart_o  = HART_ID_W'(out_hart_q);  // Zero-extended index
  assign resp_rdata_o = out_rdata_q;
  assign resp_err_o   = out_err_q;

  // Single grant, and only to a hart that has a response waiting
  a_gnt_onehot : assert property (
    @(posedge clk_i) disable iff (!rstn_i)
      $onehot0(gnt_vec) && ((gnt_vec & ~hart_valid) == '0))
    else $error("bad response grant");

endmodule : csr_resp_arb

// ==== src/csr_unit_top.sv ====
// NUM_HARTS must be a power of two from 2 to 8; MTVEC_RESET low two bits zero; up to NUM_HARTS+1 in flight
`timescale 1ns/1ns

module csr_unit_top import csr_op_pkg::*; #(
  parameter int                    NUM_HARTS   = 4,
  parameter logic [CSR_DATA_W-1:0] MTVEC_RESET = 32'h0000_0100
) (
  input  logic                  clk_i,
  input  logic                  rstn_i,

  // Request port
  input  logic                  req_valid_i,
  input  logic [HART_ID_W-1:0]  req_hart_i,
  input  csr_op_e               req_op_i,
  input  logic [CSR_ADDR_W-1:0] req_addr_i,
  input  logic [CSR_DATA_W-1:0] req_wdata_i,
  output logic                  req_ready_o,

  // Response port, two cycles after request when idle
  output logic                  resp_valid_o,
  output logic [HART_ID_W-1:0]  resp_hart_o,
  output logic [CSR_DATA_W-1:0] resp_rdata_o,
  output logic                  resp_err_o,
  input  logic                  resp_ready_i
);

  // Per-hart links
  csr_req_if hart_req [NUM_HARTS] ();
  csr_rsp_if hart_rsp [NUM_HARTS] ();

  //////////////////////////////
  // Request routing
  //////////////////////////////

  csr_dispatch #(
    .NUM_HARTS   (NUM_HARTS)
  ) i_dispatch (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .req_valid_i (req_valid_i),
    .req_hart_i  (req_hart_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_ready_o (req_ready_o),
    .hart_req    (hart_req)
  );

  //////////////////////////////
  // Register files
  //////////////////////////////

  for (genvar g = 0; g < NUM_HARTS; g++) begin : g_hart
    csr_file #(
      .HART_ID     (g),            // mhartid
      .MTVEC_RESET (MTVEC_RESET)
    ) i_file (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .req         (hart_req[g]),
      .rsp         (hart_rsp[g])
    );
  end

  //////////////////////////////
  // Response collection
  //////////////////////////////

  csr_resp_arb #(
    .NUM_HARTS    (NUM_HARTS)
  ) i_resp_arb (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .hart_rsp     (hart_rsp),
    .resp_valid_o (resp_valid_o),
    .resp_hart_o  (resp_hart_o),
    .resp_rdata_o (resp_rdata_o),
    .resp_err_o   (resp_err_o),
    .resp_ready_i (resp_ready_i)
  );

endmodule : csr_unit_top

// ==== tb/tb_csr_unit.sv ====
// Four harts, mtvec reset 32'h100; only hart numbers 0..3 are driven; per-hart reference model
`timescale 1ns/1ns

module tb_csr_unit import csr_op_pkg::*, csr_defs_pkg::*; ();

  localparam int          NH      = 4;
  localparam int          TIMEOUT = 200;           // Cycles allowed per wait
  localparam logic [31:0] SEED    = 32'hfd71bfc1;

  logic                  clk_i;
  logic                  rstn_i;
  logic                  req_valid_i;
  logic [HART_ID_W-1:0]  req_hart_i;
  csr_op_e               req_op_i;
  logic [CSR_ADDR_W-1:0] req_addr_i;
  logic [CSR_DATA_W-1:0] req_wdata_i;
  logic                  req_ready_o;
  logic                  resp_valid_o;
  logic [HART_ID_W-1:0]  resp_hart_o;
  logic [CSR_DATA_W-1:0] resp_rdata_o;
  logic                  resp_err_o;
  logic                  resp_ready_i;

  // Reference model state
  logic [31:0] m_mstatus  [NH];
  logic [31:0] m_mtvec    [NH];
  logic [31:0] m_mscratch [NH];
  logic [31:0] m_mepc     [NH];

  // Expected responses, 8-entry ring per hart, index {hart, ptr}
  logic [31:0] exp_rdata [32];
  logic        exp_err   [32];
  logic [2:0]  wr_ptr    [NH];
  logic [2:0]  rd_ptr    [NH];
  int          in_flight;                          // Accepted, not yet answered

  logic [1:0]  hh;                                 // Hart of current response
  logic [31:0] head_rdata;
  logic        head_err;
  logic        head_empty;
  logic        lat_chk;                            // Idle latency check armed
  logic        lat_fire;
  logic        lat_d1;
  logic        lat_d2;
  logic        stall_en;                           // Random resp_ready_i
  logic [31:0] rng;
  logic [31:0] rdy_rng;
  int          errors;
  int          timeouts;
  int          leftover;

  csr_unit_top #(.NUM_HARTS(NH), .MTVEC_RESET(32'h0000_0100)) i_dut (.*);

  always #4 clk_i = ~clk_i;  // 8 ns period

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Nine real CSRs, two holes, extra weight on writable ones
  function automatic logic [11:0] pick_addr(input logic [3:0] k);
    case (k)
      4'd0:    return CSR_ADDR_MVENDORID;
      4'd1:    return CSR_ADDR_MARCHID;
      4'd2:    return CSR_ADDR_MIMPID;
      4'd3:    return CSR_ADDR_MHARTID;
      4'd4:    return CSR_ADDR_MSTATUS;
      4'd5:    return CSR_ADDR_MISA;
      4'd6:    return CSR_ADDR_MTVEC;
      4'd7:    return CSR_ADDR_MSCRATCH;
      4'd8:    return CSR_ADDR_MEPC;
      4'd9:    return 12'h7C0;  // Unknown, writable range
      4'd10:   return 12'hF15;  // Unknown, read-only range
      default: return k[0] ? CSR_ADDR_MEPC : CSR_ADDR_MSCRATCH;
    endcase
  endfunction

  // Old value back, masked write, error gives zero data and no write
  task automatic model_access(input logic [1:0] h, input csr_op_e op, input logic [11:0] a,
                              input logic [31:0] wd, output logic [31:0] rd, output logic er);
    logic [31:0] old;
    logic [31:0] nv;
    logic        hit;
    logic        wr;
    old = '0;
    hit = 1'b1;
    case (a)
      CSR_ADDR_MVENDORID: old = CSR_VAL_MVENDORID;
      CSR_ADDR_MARCHID:   old = CSR_VAL_MARCHID;
      CSR_ADDR_MIMPID:    old = CSR_VAL_MIMPID;
      CSR_ADDR_MHARTID:   old = 32'(h);
      CSR_ADDR_MISA:      old = CSR_VAL_MISA;
      CSR_ADDR_MSTATUS:   old = m_mstatus[h];
      CSR_ADDR_MTVEC:     old = m_mtvec[h];
      CSR_ADDR_MSCRATCH:  old = m_mscratch[h];
      CSR_ADDR_MEPC:      old = m_mepc[h];
      default:            hit = 1'b0;
    endcase
    case (op)
      CSR_OP_RW: nv = wd;
      CSR_OP_RS: nv = old | wd;
      default:   nv = old & ~wd;
    endcase
    wr = (op == CSR_OP_RW) || (wd != 32'h0);  // Zero set/clear only reads
    er = !hit || (a[11:10] == 2'b11 && wr);
    rd = er ? 32'h0 : old;
    if (!er && wr) begin
      if (a == CSR_ADDR_MSTATUS)  m_mstatus[h]  = nv & 32'h0000_0088;  // MPIE and MIE
      if (a == CSR_ADDR_MTVEC)    m_mtvec[h]    = nv & 32'hFFFF_FFFC;  // Mode 0, direct
      if (a == CSR_ADDR_MSCRATCH) m_mscratch[h] = nv;
      if (a == CSR_ADDR_MEPC)     m_mepc[h]     = nv & 32'hFFFF_FFFC;
    end
  endtask

  // Present one request, hold it until accepted
  task automatic send(input int h, input csr_op_e op, input logic [11:0] a,
                      input logic [31:0] d);
    int n;
    n = 0;
    req_valid_i <= 1'b1;
    req_hart_i  <= HART_ID_W'(h);
    req_op_i    <= op;
    req_addr_i  <= a;
    req_wdata_i <= d;
    @(posedge clk_i);
    while (!req_ready_o && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    if (!req_ready_o) begin
      timeouts++;
      $display("Timeout: hart %0d never accepted a request", h);
    end
    req_valid_i <= 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (in_flight != 0 && n < TIMEOUT);
    if (in_flight != 0) begin
      timeouts++;
      $display("Timeout: %0d responses never came back", in_flight);
    end
  endtask

  // Isolated access, unit idle before and after
  task automatic access(input int h, input csr_op_e op, input logic [11:0] a,
                        input logic [31:0] d);
    send(h, op, a, d);
    drain();
  endtask

  task automatic read_all(input int h);
    for (int k = 0; k < 9; k++) begin
      access(h, CSR_OP_RS, pick_addr(4'(k)), 32'h0);
    end
  endtask

  //////////////////////////////
  // Scoreboard
  //////////////////////////////

  assign hh         = resp_hart_o[1:0];
  assign head_rdata = exp_rdata[{hh, rd_ptr[hh]}];
  assign head_err   = exp_err[{hh, rd_ptr[hh]}];
  assign head_empty = (rd_ptr[hh] == wr_ptr[hh]);
  assign lat_fire   = lat_chk && req_valid_i && req_ready_o && in_flight == 0 && !resp_valid_o;

  always @(posedge clk_i) begin : scoreboard
    logic [1:0]  h;
    logic [31:0] rd;
    logic        er;
    int          delta;
    delta = 0;
    if (!rstn_i) begin
      for (int i = 0; i < NH; i++) begin
        m_mstatus[i]  = '0;
        m_mtvec[i]    = 32'h0000_0100;  // Same as MTVEC_RESET above
        m_mscratch[i] = '0;
        m_mepc[i]     = '0;
        wr_ptr[i]    <= '0;
        rd_ptr[i]    <= '0;
      end
      in_flight <= 0;
      lat_d1    <= 1'b0;
      lat_d2    <= 1'b0;
    end else begin
      if (req_valid_i && req_ready_o) begin  // Request transfer
        h = req_hart_i[1:0];
        model_access(h, req_op_i, req_addr_i, req_wdata_i, rd, er);
        exp_rdata[{h, wr_ptr[h]}] <= rd;
        exp_err[{h, wr_ptr[h]}]   <= er;
        wr_ptr[h] <= wr_ptr[h] + 3'd1;
        delta++;
      end
      if (resp_valid_o && resp_ready_i && !head_empty) begin
        rd_ptr[hh] <= rd_ptr[hh] + 3'd1;
        delta--;
      end
      in_flight <= in_flight + delta;
      lat_d1    <= lat_fire;
      lat_d2    <= lat_d1;
    end
  end

  // Downstream stalls about one cycle in four
  always @(posedge clk_i) begin
    if (stall_en) begin
      rdy_rng = lcg_step(rdy_rng);
      resp_ready_i <= (rdy_rng[31:30] != 2'b00);
    end else begin
      resp_ready_i <= 1'b1;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_resp_known : assert property (@(posedge clk_i) disable iff (!rstn_i)
      resp_valid_o && resp_ready_i |-> !head_empty && !resp_hart_o[2])
    else begin
      errors++;
      $display("[FAIL] %0t response from hart %0d with nothing outstanding",
               $time, $sampled(resp_hart_o));
    end

  a_resp_match : assert property (@(posedge clk_i) disable iff (!rstn_i)
      resp_valid_o && resp_ready_i && !head_empty
      |-> resp_rdata_o == head_rdata && resp_err_o == head_err)
    else begin
      errors++;
      $display("[FAIL] %0t hart %0d gave %h err %0b, expected %h err %0b", $time,
               $sampled(hh), $sampled(resp_rdata_o), $sampled(resp_err_o),
               $sampled(head_rdata), $sampled(head_err));
    end

  a_resp_hold : assert property (@(posedge clk_i) disable iff (!rstn_i)
      resp_valid_o && !resp_ready_i
      |=> resp_valid_o && $stable({resp_hart_o, resp_rdata_o, resp_err_o}))
    else begin
      errors++;
      $display("[FAIL] %0t stalled response dropped or changed", $time);
    end

  a_reset_idle : assert property (@(posedge clk_i) !rstn_i |=> !resp_valid_o)
    else begin
      errors++;
      $display("[FAIL] %0t resp_valid_o high out of reset", $time);
    end

  // Idle unit answers on the second edge after the transfer, not before
  a_lat_early : assert property (@(posedge clk_i) disable iff (!rstn_i) lat_d1 |-> !resp_valid_o)
    else begin
      errors++;
      $display("[FAIL] %0t response one cycle early", $time);
    end

  a_lat_due : assert property (@(posedge clk_i) disable iff (!rstn_i) lat_d2 |-> resp_valid_o)
    else begin
      errors++;
      $display("[FAIL] %0t response missing two cycles after request", $time);
    end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int          gap;
    csr_op_e     op;
    logic [31:0] d;
    clk_i        = 1'b0;
    rstn_i       = 1'b0;
    req_valid_i  = 1'b0;
    req_hart_i   = '0;
    req_op_i     = CSR_OP_RS;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    resp_ready_i = 1'b1;
    lat_chk      = 1'b0;
    stall_en     = 1'b0;
    rng          = SEED;
    rdy_rng      = ~SEED;
    errors       = 0;
    timeouts     = 0;
    leftover     = 0;
    repeat (4) @(posedge clk_i);
    rstn_i  <= 1'b1;
    lat_chk <= 1'b1;

    for (int h = 0; h < NH; h++) read_all(h);  // Reset values

    // Write masks on hart 1
    access(1, CSR_OP_RW, CSR_ADDR_MSTATUS, 32'hFFFF_FFFF);
    access(1, CSR_OP_RC, CSR_ADDR_MSTATUS, 32'h0000_0008);  // MIE only
    access(1, CSR_OP_RW, CSR_ADDR_MTVEC, 32'hFFFF_FFFF);
    access(1, CSR_OP_RW, CSR_ADDR_MEPC, 32'hFFFF_FFFF);
    access(1, CSR_OP_RW, CSR_ADDR_MSCRATCH, 32'hFFFF_FFFF);
    access(1, CSR_OP_RW, CSR_ADDR_MISA, 32'h0000_0000);     // Ignored
    read_all(1);

    // Set and clear on hart 2
    access(2, CSR_OP_RW, CSR_ADDR_MSCRATCH, 32'h1234_5678);
    access(2, CSR_OP_RS, CSR_ADDR_MSCRATCH, 32'h0F00_00F0);
    access(2, CSR_OP_RC, CSR_ADDR_MSCRATCH, 32'h1200_0008);
    access(2, CSR_OP_RS, CSR_ADDR_MSCRATCH, 32'h0);

    // Errors on hart 3
    access(3, CSR_OP_RW, CSR_ADDR_MSCRATCH, 32'hCAFE_0003);
    access(3, CSR_OP_RW, 12'h7C0, 32'hFFFF_FFFF);
    access(3, CSR_OP_RS, CSR_ADDR_MVENDORID, 32'h0000_0001);
    access(3, CSR_OP_RW, CSR_ADDR_MHARTID, 32'h0);           // RW always writes
    access(3, CSR_OP_RC, CSR_ADDR_MHARTID, 32'h0000_0004);
    access(3, CSR_OP_RS, CSR_ADDR_MHARTID, 32'h0);           // Plain read, no error
    read_all(3);

    // Random traffic with back-pressure
    lat_chk  <= 1'b0;
    stall_en <= 1'b1;
    for (int i = 0; i < 600; i++) begin
      rng = lcg_step(rng);
      d   = rng;
      rng = lcg_step(rng);
      op  = (rng[29:28] == 2'b00) ? CSR_OP_RW : csr_op_e'(rng[29:28]);
      gap = rng[21] ? 0 : int'(rng[20:19]);
      send(int'(rng[31:30]), op, pick_addr(rng[27:24]), (rng[23:22] == 2'b00) ? 32'h0 : d);
      repeat (gap) @(posedge clk_i);
    end
    stall_en <= 1'b0;
    drain();
    lat_chk <= 1'b1;
    for (int h = 0; h < NH; h++) read_all(h);  // No cross-hart effects

    for (int h = 0; h < NH; h++) begin
      if (rd_ptr[h] != wr_ptr[h]) begin
        leftover++;
        $display("Hart %0d has expected responses that never arrived", h);
      end
    end
    $display("Errors: %0d check, %0d timeout, %0d leftover", errors, timeouts, leftover);
    if (errors == 0 && timeouts == 0 && leftover == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : tb_csr_unit

// ==== flist.f ====
src/csr_op_pkg.sv
src/csr_defs_pkg.sv
src/csr_req_if.sv
src/csr_dispatch.sv
src/csr_file.sv
src/csr_resp_arb.sv
src/csr_unit_top.sv
tb/tb_csr_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator, pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_csr_unit -f flist.f \
  && ./obj_dir/Vtb_csr_unit | tee /dev/stderr | grep -qx "all tests passed" \
  && exit 0 \
  || exit 1
